// File: Bender.yml
package:
  name: vec_alu

sources:
  - include_dirs:
      - .
    files:
      - vec_isa_pkg.sv
      - vec_data_pkg.sv
      - vec_logic_permute.sv
      - vec_addsub.sv
      - vec_shifter.sv
      - vec_mult_even_odd.sv
      - vec_result_stage.sv
      - vec_alu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - vec_alu_assertions.sv
      - tb_vec_alu.sv

// File: all.f
+incdir+.
vec_isa_pkg.sv
vec_data_pkg.sv
vec_logic_permute.sv
vec_addsub.sv
vec_shifter.sv
vec_mult_even_odd.sv
vec_result_stage.sv
vec_alu_top.sv
vec_alu_assertions.sv
tb_vec_alu.sv

// File: tb_vec_alu.sv
`timescale 1ns/1ps
`include "vec_alu_params.svh"

module tb_vec_alu;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	// Upper bound on the operations issued by all tests together
	localparam int NUM_OPS = 150;
	localparam int WATCHDOG_CYCLES = NUM_OPS * 3 * 2 + RESET_CYCLES;

	logic                     clk;
	logic                     reset;
	logic                     alu_en;
	vec_isa_pkg::vec_op_e     op;
	vec_isa_pkg::elem_width_e ww;
	vec_data_pkg::vec_word_t  ra;
	vec_data_pkg::vec_word_t  rb;
	vec_data_pkg::vec_word_t  alu_out;
	logic                     result_valid;

	integer seed;
	int     errors;
	int     checks;

	vec_alu_top dut0 (
		.clk          (clk),
		.reset        (reset),
		.alu_en       (alu_en),
		.op           (op),
		.ww           (ww),
		.ra           (ra),
		.rb           (rb),
		.alu_out      (alu_out),
		.result_valid (result_valid)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	function automatic logic [63:0] rand_word();
		rand_word = {$random(seed), $random(seed)};
	endfunction

	function automatic logic [63:0] lane_mask(int w);
		if (w >= `VEC_WIDTH)
			lane_mask = '1;
		else
			lane_mask = (64'd1 << w) - 64'd1;
	endfunction

	// Lane 0 is the most significant lane
	function automatic logic [63:0] get_lane(logic [63:0] x, int w, int i);
		get_lane = (x >> (`VEC_WIDTH - (i + 1) * w)) & lane_mask(w);
	endfunction

	// One lane of the add, subtract, shift and half swap operations
	function automatic logic [63:0] lane_op(vec_isa_pkg::vec_op_e o, int w,
			logic [63:0] la, logic [63:0] lb);
		logic [63:0] m;
		int          amt;

		m = lane_mask(w);
		amt = int'(lb & (w - 1));
		case (o)
			vec_isa_pkg::VRTTH: lane_op = ((la << (w / 2)) | (la >> (w / 2))) & m;
			vec_isa_pkg::VADD:  lane_op = (la + lb) & m;
			vec_isa_pkg::VSUB:  lane_op = (la - lb) & m;
			vec_isa_pkg::VSLL:  lane_op = (la << amt) & m;
			vec_isa_pkg::VSRL:  lane_op = la >> amt;
			vec_isa_pkg::VSRA: begin
				if (la[w-1])
					lane_op = (la >> amt) | (m & ~(m >> amt));
				else
					lane_op = la >> amt;
			end
			default: lane_op = '0;
		endcase
	endfunction

	function automatic logic [63:0] model_result(vec_isa_pkg::vec_op_e o,
			vec_isa_pkg::elem_width_e w_code, logic [63:0] a, logic [63:0] b);
		int          w;
		int          n;
		int          j;
		logic [63:0] la;
		logic [63:0] lb;
		logic [63:0] res;

		w = 8 << w_code;
		n = `VEC_WIDTH / w;
		res = '0;
		case (o)
			vec_isa_pkg::VAND: res = a & b;
			vec_isa_pkg::VOR:  res = a | b;
			vec_isa_pkg::VXOR: res = a ^ b;
			vec_isa_pkg::VNOT: res = ~a;
			vec_isa_pkg::VMOV: res = a;
			vec_isa_pkg::VRTTH, vec_isa_pkg::VADD, vec_isa_pkg::VSUB,
			vec_isa_pkg::VSLL, vec_isa_pkg::VSRL, vec_isa_pkg::VSRA: begin
				for (int i = 0; i < n; i++) begin
					la = lane_op(o, w, get_lane(a, w, i), get_lane(b, w, i));
					res = res | (la << (`VEC_WIDTH - (i + 1) * w));
				end
			end
			vec_isa_pkg::VMULEU, vec_isa_pkg::VMULOU,
			vec_isa_pkg::VSQEU, vec_isa_pkg::VSQOU: begin
				// Product k lands in double-width lane k and 64-bit lanes give none
				if (w < `VEC_WIDTH) begin
					for (int k = 0; k < n / 2; k++) begin
						j = 2 * k + ((o == vec_isa_pkg::VMULOU || o == vec_isa_pkg::VSQOU) ? 1 : 0);
						la = get_lane(a, w, j);
						if (o == vec_isa_pkg::VSQEU || o == vec_isa_pkg::VSQOU)
							lb = la;
						else
							lb = get_lane(b, w, j);
						res = res | ((la * lb) << (`VEC_WIDTH - (k + 1) * 2 * w));
					end
				end
			end
			default: res = '0;
		endcase
		model_result = res;
	endfunction

	task automatic check_word(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic wait_valid(output bit seen);
		int n;

		n = 0;
		@(negedge clk);
		while (result_valid !== 1'b1 && n < 3) begin
			@(negedge clk);
			n++;
		end
		seen = (result_valid === 1'b1);
		if (!seen) begin
			errors++;
			$display("No valid pulse came back after the enable, t=%0t", $time);
		end
	endtask

	task automatic run_op_exp(input vec_isa_pkg::vec_op_e o,
			input vec_isa_pkg::elem_width_e w, input logic [63:0] a,
			input logic [63:0] b, input logic [63:0] exp);
		bit seen;

		@(posedge clk);
		alu_en <= 1'b1;
		op <= o;
		ww <= w;
		ra <= a;
		rb <= b;
		@(posedge clk);
		alu_en <= 1'b0;
		wait_valid(seen);
		if (seen)
			check_word($sformatf("alu_out %s %s", o.name(), w.name()), exp, alu_out);
	endtask

	task automatic run_op(input vec_isa_pkg::vec_op_e o,
			input vec_isa_pkg::elem_width_e w, input logic [63:0] a, input logic [63:0] b);
		run_op_exp(o, w, a, b, model_result(o, w, a, b));
	endtask

	task automatic test_reset_enable();
		vec_isa_pkg::vec_op_e     ops [0:3];
		vec_isa_pkg::elem_width_e wws [0:3];
		logic [63:0]              a [0:3];
		logic [63:0]              b [0:3];
		logic [63:0]              exp [0:3];

		ops = '{vec_isa_pkg::VADD, vec_isa_pkg::VXOR, vec_isa_pkg::VSLL, vec_isa_pkg::VMULEU};
		wws = '{vec_isa_pkg::W16, vec_isa_pkg::W8, vec_isa_pkg::W32, vec_isa_pkg::W8};
		@(negedge clk);
		check_bit("result_valid", 1'b0, result_valid);
		check_word("alu_out", 64'd0, alu_out);
		// Inputs change while the enable stays low
		for (int i = 0; i < 3; i++) begin
			@(posedge clk);
			op <= vec_isa_pkg::VADD;
			ra <= rand_word();
			rb <= rand_word();
			@(negedge clk);
			check_bit("result_valid", 1'b0, result_valid);
			check_word("alu_out", 64'd0, alu_out);
		end
		for (int i = 0; i < 4; i++) begin
			a[i] = rand_word();
			b[i] = rand_word();
			exp[i] = model_result(ops[i], wws[i], a[i], b[i]);
		end
		for (int i = 0; i <= 4; i++) begin
			@(posedge clk);
			if (i < 4) begin
				alu_en <= 1'b1;
				op <= ops[i];
				ww <= wws[i];
				ra <= a[i];
				rb <= b[i];
			end else begin
				alu_en <= 1'b0;
			end
			@(negedge clk);
			if (i > 0) begin
				check_bit("result_valid", 1'b1, result_valid);
				check_word("alu_out back-to-back", exp[i-1], alu_out);
			end
		end
		@(negedge clk);
		check_bit("result_valid", 1'b0, result_valid);
		check_word("alu_out held", exp[3], alu_out);
	endtask

	task automatic test_bitwise();
		vec_isa_pkg::vec_op_e ops [0:5];

		ops = '{vec_isa_pkg::VAND, vec_isa_pkg::VOR, vec_isa_pkg::VXOR,
			vec_isa_pkg::VNOT, vec_isa_pkg::VMOV, vec_isa_pkg::VRTTH};
		for (int w = 0; w < 4; w++) begin
			for (int k = 0; k < 6; k++) begin
				run_op(ops[k], vec_isa_pkg::elem_width_e'(w),
					64'h0123456789abcdef, 64'hff00f0f0cc33aa55);
				run_op(ops[k], vec_isa_pkg::elem_width_e'(w), rand_word(), rand_word());
			end
		end
	endtask

	task automatic test_addsub();
		vec_isa_pkg::vec_op_e ops [0:1];

		ops = '{vec_isa_pkg::VADD, vec_isa_pkg::VSUB};
		for (int w = 0; w < 4; w++) begin
			for (int k = 0; k < 2; k++) begin
				run_op(ops[k], vec_isa_pkg::elem_width_e'(w),
					64'h00ffffff7fffffff, 64'h0001000100010001);
				run_op(ops[k], vec_isa_pkg::elem_width_e'(w),
					64'h0100000080000000, 64'h0001000100010001);
				run_op(ops[k], vec_isa_pkg::elem_width_e'(w), rand_word(), rand_word());
			end
		end
		// Carry reaches the next byte but stops at the lane boundary
		run_op_exp(vec_isa_pkg::VADD, vec_isa_pkg::W16, 64'h00ff00ff00ff00ff,
			64'h0001000100010001, 64'h0100010001000100);
		run_op_exp(vec_isa_pkg::VADD, vec_isa_pkg::W8, 64'hffffffffffffffff,
			64'h0101010101010101, 64'h0);
		run_op_exp(vec_isa_pkg::VSUB, vec_isa_pkg::W32, 64'h0000000100000000,
			64'h0000000000000001, 64'h00000001ffffffff);
	endtask

	task automatic test_shift();
		vec_isa_pkg::vec_op_e ops [0:2];

		ops = '{vec_isa_pkg::VSLL, vec_isa_pkg::VSRL, vec_isa_pkg::VSRA};
		for (int w = 0; w < 4; w++) begin
			for (int k = 0; k < 3; k++) begin
				run_op(ops[k], vec_isa_pkg::elem_width_e'(w),
					64'h8081f00080000001, 64'h03070f0a1f053f02);
				run_op(ops[k], vec_isa_pkg::elem_width_e'(w), rand_word(), rand_word());
			end
		end
		run_op_exp(vec_isa_pkg::VSRA, vec_isa_pkg::W8, 64'h8080808080808080,
			64'h0102030405060707, 64'hc0e0f0f8fcfeffff);
	endtask

	task automatic test_mult();
		vec_isa_pkg::vec_op_e ops [0:3];

		ops = '{vec_isa_pkg::VMULEU, vec_isa_pkg::VMULOU, vec_isa_pkg::VSQEU, vec_isa_pkg::VSQOU};
		for (int w = 0; w < 3; w++) begin
			for (int k = 0; k < 4; k++) begin
				run_op(ops[k], vec_isa_pkg::elem_width_e'(w), '1, '1);
				run_op(ops[k], vec_isa_pkg::elem_width_e'(w), rand_word(), rand_word());
			end
		end
		run_op_exp(vec_isa_pkg::VMULOU, vec_isa_pkg::W16, '1, '1, 64'hfffe0001fffe0001);
		run_op_exp(vec_isa_pkg::VSQEU, vec_isa_pkg::W32, 64'h0000000200000003,
			rand_word(), 64'h4);
		run_op_exp(vec_isa_pkg::VSQOU, vec_isa_pkg::W32, 64'h0000000200000003,
			rand_word(), 64'h9);
		for (int k = 0; k < 4; k++)
			run_op_exp(ops[k], vec_isa_pkg::W64, rand_word(), rand_word(), 64'h0);
		// NOP and reserved opcodes
		run_op_exp(vec_isa_pkg::VNOP, vec_isa_pkg::W8, rand_word(), rand_word(), 64'h0);
		run_op_exp(vec_isa_pkg::vec_op_e'(14), vec_isa_pkg::W8, rand_word(), rand_word(), 64'h0);
		run_op_exp(vec_isa_pkg::vec_op_e'(15), vec_isa_pkg::W16, rand_word(), rand_word(), 64'h0);
		run_op_exp(vec_isa_pkg::vec_op_e'(18), vec_isa_pkg::W32, rand_word(), rand_word(), 64'h0);
	endtask

	initial begin
		seed = 32'hf745;
		errors = 0;
		checks = 0;
		reset = 1'b1;
		// Enabled NOT of zero pending while reset holds the outputs clear
		alu_en = 1'b1;
		op = vec_isa_pkg::VNOT;
		ww = vec_isa_pkg::W8;
		ra = '0;
		rb = '0;
		repeat (RESET_CYCLES - 4) @(posedge clk);
		alu_en <= 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		test_reset_enable();
		test_bitwise();
		test_addsub();
		test_shift();
		test_mult();

		@(posedge clk);
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, dut0.u_assert.assert_failures);
		if (errors == 0 && dut0.u_assert.assert_failures == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: vec_addsub.sv
`timescale 1ns/1ps
`include "vec_alu_params.svh"

module vec_addsub (
	input  vec_data_pkg::vec_word_t   ra,
	input  vec_data_pkg::vec_word_t   rb,
	input  vec_isa_pkg::vec_op_e      op,
	input  vec_isa_pkg::elem_width_e  ww,
	output vec_data_pkg::vec_word_t   result
);

	always_comb begin
		logic       sub;
		logic       carry;
		logic       cin;
		logic [0:2] lane_mask;
		logic [0:8] sum;

		result = '0;
		sub = (op == vec_isa_pkg::VSUB);
		carry = 1'b0;
		cin = 1'b0;
		sum = '0;

		// Bytes per lane minus one
		case (ww)
			vec_isa_pkg::W8:  lane_mask = 3'd0;
			vec_isa_pkg::W16: lane_mask = 3'd1;
			vec_isa_pkg::W32: lane_mask = 3'd3;
			default:          lane_mask = 3'd7;
		endcase

		if (op == vec_isa_pkg::VADD || op == vec_isa_pkg::VSUB) begin
			// Ripple from the least significant byte slice upward
			for (int s = `VEC_BYTES - 1; s >= 0; s--) begin
				// Lane boundary restarts the chain, 1 for subtract
				if (s == `VEC_BYTES - 1 || ((s + 1) & lane_mask) == 0)
					cin = sub;
				else
					cin = carry;
				sum = {1'b0, ra[s*8 +: 8]} + {1'b0, rb[s*8 +: 8] ^ {8{sub}}} + cin;
				result[s*8 +: 8] = sum[1:8];
				carry = sum[0];
			end
		end
	end

endmodule

// File: vec_alu_assertions.sv
`timescale 1ns/1ps

module vec_alu_assertions (
	input logic                    clk,
	input logic                    reset,
	input logic                    alu_en,
	input logic                    result_valid,
	input vec_data_pkg::vec_word_t alu_out
);

	int assert_failures = 0;

	// Reset clears the valid flag
	valid_low_in_reset: assert property (@(posedge clk) reset |=> !result_valid)
		else begin
			$error("result_valid is high after a reset cycle");
			assert_failures++;
		end

	// One cycle behind the enable
	valid_follows_enable: assert property (@(posedge clk) disable iff (reset)
		1'b1 |=> (result_valid == $past(alu_en)))
		else begin
			$error("result_valid does not follow alu_en of the previous cycle");
			assert_failures++;
		end

	out_known_when_valid: assert property (@(posedge clk) result_valid |-> !$isunknown(alu_out))
		else begin
			$error("alu_out has unknown bits while result_valid is high");
			assert_failures++;
		end

endmodule

bind vec_alu_top vec_alu_assertions u_assert (
	.clk          (clk),
	.reset        (reset),
	.alu_en       (alu_en),
	.result_valid (result_valid),
	.alu_out      (alu_out)
);

// File: vec_alu_params.svh
`ifndef VEC_ALU_PARAMS_SVH
`define VEC_ALU_PARAMS_SVH

// Vector word size in bits
`define VEC_WIDTH 64

// Byte slices in one vector word
`define VEC_BYTES 8

// Opcode field size
`define VEC_OP_BITS 6

// Element width code size
`define VEC_WW_BITS 2

`endif

// File: vec_alu_top.sv
`timescale 1ns/1ps

module vec_alu_top (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       alu_en,
	input  vec_isa_pkg::vec_op_e       op,
	input  vec_isa_pkg::elem_width_e   ww,
	input  vec_data_pkg::vec_word_t    ra,
	input  vec_data_pkg::vec_word_t    rb,
	output vec_data_pkg::vec_word_t    alu_out,
	output logic                       result_valid
);

	vec_data_pkg::vec_word_t logic_res;
	vec_data_pkg::vec_word_t addsub_res;
	vec_data_pkg::vec_word_t shift_res;
	vec_data_pkg::vec_word_t mult_res;

	vec_logic_permute u_logic (
		.ra     (ra),
		.rb     (rb),
		.op     (op),
		.ww     (ww),
		.result (logic_res)
	);

	vec_addsub u_addsub (
		.ra     (ra),
		.rb     (rb),
		.op     (op),
		.ww     (ww),
		.result (addsub_res)
	);

	vec_shifter u_shifter (
		.ra     (ra),
		.rb     (rb),
		.op     (op),
		.ww     (ww),
		.result (shift_res)
	);

	vec_mult_even_odd u_mult (
		.ra     (ra),
		.rb     (rb),
		.op     (op),
		.ww     (ww),
		.result (mult_res)
	);

	// Only registered stage in the ALU
	vec_result_stage u_result (
		.clk          (clk),
		.reset        (reset),
		.alu_en       (alu_en),
		.op           (op),
		.logic_res    (logic_res),
		.addsub_res   (addsub_res),
		.shift_res    (shift_res),
		.mult_res     (mult_res),
		.alu_out      (alu_out),
		.result_valid (result_valid)
	);

endmodule

// File: vec_data_pkg.sv
`include "vec_alu_params.svh"

package vec_data_pkg;

	// Bit 0 is the most significant bit, lane 0 sits at the top
	typedef logic [0:`VEC_WIDTH-1] vec_word_t;

	// Widening products of 8, 16 and 32 bit lanes
	typedef logic [0:15] prod16_t;
	typedef logic [0:31] prod32_t;
	typedef logic [0:63] prod64_t;

endpackage

// File: vec_isa_pkg.sv
`include "vec_alu_params.svh"

package vec_isa_pkg;

	// Opcode encoding, values 14, 15 and 18 are reserved
	typedef enum logic [0:`VEC_OP_BITS-1] {
		VNOP   = 0,
		VAND   = 1,
		VOR    = 2,
		VXOR   = 3,
		VNOT   = 4,
		VMOV   = 5,
		VADD   = 6,
		VSUB   = 7,
		VMULEU = 8,
		VMULOU = 9,
		VSLL   = 10,
		VSRL   = 11,
		VSRA   = 12,
		VRTTH  = 13,
		VSQEU  = 16,
		VSQOU  = 17
	} vec_op_e;

	// Lane width code
	typedef enum logic [0:`VEC_WW_BITS-1] {
		W8  = 0,
		W16 = 1,
		W32 = 2,
		W64 = 3
	} elem_width_e;

endpackage

// File: vec_logic_permute.sv
`timescale 1ns/1ps

module vec_logic_permute (
	input  vec_data_pkg::vec_word_t   ra,
	input  vec_data_pkg::vec_word_t   rb,
	input  vec_isa_pkg::vec_op_e      op,
	input  vec_isa_pkg::elem_width_e  ww,
	output vec_data_pkg::vec_word_t   result
);

	always_comb begin
		result = '0;
		case (op)
			vec_isa_pkg::VAND: result = ra & rb;
			vec_isa_pkg::VOR:  result = ra | rb;
			vec_isa_pkg::VXOR: result = ra ^ rb;
			vec_isa_pkg::VNOT: result = ~ra;
			vec_isa_pkg::VMOV: result = ra;
			vec_isa_pkg::VRTTH: begin
				// Swap upper and lower half inside every lane
				case (ww)
					vec_isa_pkg::W8: begin
						for (int i = 0; i < 8; i++) begin
							result[i*8 +: 8] = {ra[i*8+4 +: 4], ra[i*8 +: 4]};
						end
					end
					vec_isa_pkg::W16: begin
						for (int i = 0; i < 4; i++) begin
							result[i*16 +: 16] = {ra[i*16+8 +: 8], ra[i*16 +: 8]};
						end
					end
					vec_isa_pkg::W32: begin
						for (int i = 0; i < 2; i++) begin
							result[i*32 +: 32] = {ra[i*32+16 +: 16], ra[i*32 +: 16]};
						end
					end
					default: result = {ra[32:63], ra[0:31]};
				endcase
			end
			default: result = '0;
		endcase
	end

endmodule

// File: vec_mult_even_odd.sv
`timescale 1ns/1ps

module vec_mult_even_odd (
	input  vec_data_pkg::vec_word_t   ra,
	input  vec_data_pkg::vec_word_t   rb,
	input  vec_isa_pkg::vec_op_e      op,
	input  vec_isa_pkg::elem_width_e  ww,
	output vec_data_pkg::vec_word_t   result
);

	logic                    active;
	logic                    sel;
	vec_data_pkg::vec_word_t b_src;

	// Odd variants pick lanes 1, 3, 5 and so on
	always_comb begin
		active = 1'b1;
		sel = 1'b0;
		b_src = rb;
		case (op)
			vec_isa_pkg::VMULEU: sel = 1'b0;
			vec_isa_pkg::VMULOU: sel = 1'b1;
			vec_isa_pkg::VSQEU:  b_src = ra;
			vec_isa_pkg::VSQOU: begin
				sel = 1'b1;
				b_src = ra;
			end
			default: active = 1'b0;
		endcase
	end

	always_comb begin
		vec_data_pkg::prod16_t p16;
		vec_data_pkg::prod32_t p32;
		vec_data_pkg::prod64_t p64;

		result = '0;
		p16 = '0;
		p32 = '0;
		p64 = '0;
		if (active) begin
			case (ww)
				vec_isa_pkg::W8: begin
					for (int k = 0; k < 4; k++) begin
						p16 = ra[(2*k + sel)*8 +: 8] * b_src[(2*k + sel)*8 +: 8];
						result[k*16 +: 16] = p16;
					end
				end
				vec_isa_pkg::W16: begin
					for (int k = 0; k < 2; k++) begin
						p32 = ra[(2*k + sel)*16 +: 16] * b_src[(2*k + sel)*16 +: 16];
						result[k*32 +: 32] = p32;
					end
				end
				vec_isa_pkg::W32: begin
					p64 = ra[sel*32 +: 32] * b_src[sel*32 +: 32];
					result = p64;
				end
				// No 128 bit product lane
				default: result = '0;
			endcase
		end
	end

endmodule

// File: vec_result_stage.sv
`timescale 1ns/1ps

module vec_result_stage (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     alu_en,
	input  vec_isa_pkg::vec_op_e     op,
	input  vec_data_pkg::vec_word_t  logic_res,
	input  vec_data_pkg::vec_word_t  addsub_res,
	input  vec_data_pkg::vec_word_t  shift_res,
	input  vec_data_pkg::vec_word_t  mult_res,
	output vec_data_pkg::vec_word_t  alu_out,
	output logic                     result_valid
);

	typedef enum logic [0:2] {
		CLS_NONE   = 0,
		CLS_LOGIC  = 1,
		CLS_ADDSUB = 2,
		CLS_SHIFT  = 3,
		CLS_MULT   = 4
	} unit_class_e;

	unit_class_e             cls;
	vec_data_pkg::vec_word_t next_word;

	// Opcode to unit class
	always_comb begin
		case (op)
			vec_isa_pkg::VAND, vec_isa_pkg::VOR, vec_isa_pkg::VXOR,
			vec_isa_pkg::VNOT, vec_isa_pkg::VMOV, vec_isa_pkg::VRTTH:
				cls = CLS_LOGIC;
			vec_isa_pkg::VADD, vec_isa_pkg::VSUB:
				cls = CLS_ADDSUB;
			vec_isa_pkg::VSLL, vec_isa_pkg::VSRL, vec_isa_pkg::VSRA:
				cls = CLS_SHIFT;
			vec_isa_pkg::VMULEU, vec_isa_pkg::VMULOU,
			vec_isa_pkg::VSQEU, vec_isa_pkg::VSQOU:
				cls = CLS_MULT;
			default:
				cls = CLS_NONE;
		endcase
	end

	always_comb begin
		case (cls)
			CLS_LOGIC:  next_word = logic_res;
			CLS_ADDSUB: next_word = addsub_res;
			CLS_SHIFT:  next_word = shift_res;
			CLS_MULT:   next_word = mult_res;
			default:    next_word = '0;
		endcase
	end

	// One cycle behind the enable, holds when idle
	always_ff @(posedge clk) begin
		if (reset) begin
			alu_out <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= alu_en;
			if (alu_en)
				alu_out <= next_word;
		end
	end

endmodule

// File: vec_shifter.sv
`timescale 1ns/1ps

module vec_shifter (
	input  vec_data_pkg::vec_word_t   ra,
	input  vec_data_pkg::vec_word_t   rb,
	input  vec_isa_pkg::vec_op_e      op,
	input  vec_isa_pkg::elem_width_e  ww,
	output vec_data_pkg::vec_word_t   result
);

	// Lane value sits left aligned with zeros below it
	function automatic vec_data_pkg::vec_word_t lane_shift(
		vec_data_pkg::vec_word_t a,
		logic [0:5]              amt,
		vec_isa_pkg::vec_op_e    f
	);
		case (f)
			vec_isa_pkg::VSLL: lane_shift = a << amt;
			vec_isa_pkg::VSRL: lane_shift = a >> amt;
			// Sign comes from the lane top bit at index 0
			vec_isa_pkg::VSRA: lane_shift = $signed(a) >>> amt;
			default:           lane_shift = '0;
		endcase
	endfunction

	always_comb begin
		vec_data_pkg::vec_word_t tmp;

		result = '0;
		case (ww)
			vec_isa_pkg::W8: begin
				for (int i = 0; i < 8; i++) begin
					tmp = lane_shift({ra[i*8 +: 8], 56'd0}, rb[i*8+5 +: 3], op);
					result[i*8 +: 8] = tmp[0:7];
				end
			end
			vec_isa_pkg::W16: begin
				for (int i = 0; i < 4; i++) begin
					tmp = lane_shift({ra[i*16 +: 16], 48'd0}, rb[i*16+12 +: 4], op);
					result[i*16 +: 16] = tmp[0:15];
				end
			end
			vec_isa_pkg::W32: begin
				for (int i = 0; i < 2; i++) begin
					tmp = lane_shift({ra[i*32 +: 32], 32'd0}, rb[i*32+27 +: 5], op);
					result[i*32 +: 32] = tmp[0:31];
				end
			end
			default: begin
				tmp = lane_shift(ra, rb[58:63], op);
				result = tmp;
			end
		endcase
	end

endmodule
